// File: compile.f
src/obj_geom_pkg.sv
src/obj_fmt_pkg.sv
src/obj_table_ram.sv
src/obj_scan_fsm.sv
src/obj_pxl_count.sv
src/obj_draw.sv
src/obj_line_buf.sv
src/obj_layer.sv
tb/obj_rom_model.sv
tb/tb_obj_layer.sv

// File: src/obj_draw.sv
`timescale 1ns/1ps
`default_nettype none

module obj_draw (
    input  wire                               clk,
    input  wire                               rst,
    input  wire                               draw_start,
    input  wire  [obj_geom_pkg::row_w-1:0]    obj_row,
    input  wire  [obj_fmt_pkg::byte_w-1:0]    obj_code,
    input  wire  [obj_fmt_pkg::byte_w-1:0]    obj_bank,
    input  wire  [obj_geom_pkg::x_w-1:0]      obj_x,
    input  wire  [obj_fmt_pkg::byte_w-1:0]    obj_attr,
    input  wire  [obj_fmt_pkg::rom_dw-1:0]    rom_data,
    input  wire                               rom_ok,
    output logic [obj_fmt_pkg::rom_aw-1:0]    rom_addr,
    output logic                              draw_done,
    output logic                              buf_we,
    output logic [obj_geom_pkg::x_w-1:0]      buf_x,
    output logic [obj_fmt_pkg::pxl_w-1:0]     buf_data
);
    import obj_geom_pkg::*;
    import obj_fmt_pkg::*;

    logic              busy, fetch, ok_dly, step, last;
    logic [pxl_iw-1:0] pxl_idx;
    logic [word_w-1:0] word;
    logic [rom_dw-1:0] planar, shift;
    logic [col_w-1:0]  col;
    logic              hflip, vflip;

    assign hflip = obj_attr[attr_hflip];
    assign vflip = obj_attr[attr_vflip];

    // word index comes from the upper pixel bits
    assign word     = pxl_idx[pxl_iw-1 -: word_w] ^ {word_w{hflip}};
    assign rom_addr = {obj_bank[bank_lo +: bank_w], obj_code, obj_row ^ {row_w{vflip}}, word};

    always_comb begin
        for (int k = 0; k < rom_dw / col_w; k++) begin
            planar[col_w*k +: col_w] = {rom_data[k+12], rom_data[k+8], rom_data[k+4], rom_data[k]};
        end
    end

    assign col      = hflip ? shift[rom_dw-1 -: col_w] : shift[col_w-1:0];
    assign step     = busy & ~fetch & rom_ok;  // rom_ok low stalls writes too
    assign buf_we   = step & (col != '0);      // colour 0 is transparent
    assign buf_data = {obj_bank[pal_lo +: pal_w], col};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy      <= 1'b0;
            fetch     <= 1'b0;
            ok_dly    <= 1'b0;
            draw_done <= 1'b0;
        end else begin
            draw_done <= 1'b0;
            ok_dly    <= rom_ok;
            if (draw_start) begin
                busy   <= 1'b1;
                fetch  <= 1'b1;
                ok_dly <= 1'b0;
            end else if (fetch) begin
                if (ok_dly && rom_ok)
                    fetch <= 1'b0; // two good cycles on the new address
            end else if (step && &pxl_idx[pxl_iw-word_w-1:0]) begin
                if (last) begin
                    busy      <= 1'b0;
                    draw_done <= 1'b1;
                end else begin
                    fetch  <= 1'b1;
                    ok_dly <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch && ok_dly && rom_ok)
            shift <= planar;
        else if (step)
            shift <= hflip ? shift << col_w : shift >> col_w;
    end

    obj_pxl_count u_pxl_count (
        .clk     (clk),
        .rst     (rst),
        .start   (draw_start),
        .x0      (obj_x),
        .step    (step),
        .pxl_idx (pxl_idx),
        .pxl_x   (buf_x),
        .last    (last)
    );

endmodule

`default_nettype wire

// File: src/obj_fmt_pkg.sv
`default_nettype none

package obj_fmt_pkg;

    localparam int byte_w = 8;

    // byte order inside one table entry
    localparam int off_y    = 0;
    localparam int off_attr = 1;
    localparam int off_bank = 2;
    localparam int off_code = 3;
    localparam int off_x    = 4;

    // attr byte
    localparam int attr_en    = 7;
    localparam int attr_hflip = 3;
    localparam int attr_vflip = 2;

    // bank byte, rom bank low, palette high
    localparam int bank_lo = 0;
    localparam int bank_w  = 4;
    localparam int pal_lo  = 4;
    localparam int pal_w   = 4;

    // rom word address is {bank, code, row, word}
    localparam int rom_aw = 18;
    localparam int rom_dw = 16;
    localparam int word_w = 2;    // four words per object row

    // line buffer pixel is {palette, colour}
    localparam int pxl_w = 8;
    localparam int col_w = pxl_w - pal_w;

endpackage

`default_nettype wire

// File: src/obj_geom_pkg.sv
`default_nettype none

package obj_geom_pkg;

    // screen line
    localparam int line_w = 256;              // pixels per line
    localparam int x_w    = $clog2(line_w);   // x position bits

    // object table
    localparam int obj_count  = 64;
    localparam int obj_bytes  = 5;             // bytes per table entry
    localparam int table_aw   = 9;
    localparam int table_size = obj_count * obj_bytes;

    // per-object size and line limit
    localparam int max_per_line = 32;
    localparam int obj_h        = 16;              // rows in one object band
    localparam int row_w        = $clog2(obj_h);
    localparam int obj_w        = 16;              // pixels in one object row
    localparam int pxl_iw       = $clog2(obj_w);

endpackage

`default_nettype wire

// File: src/obj_layer.sv
`timescale 1ns/1ps
`default_nettype none

module obj_layer (
    input  wire                                clk,
    input  wire                                rst,
    input  wire  [obj_geom_pkg::table_aw-1:0]  cpu_addr,
    input  wire                                obj_cs,
    input  wire                                cpu_wrn,
    input  wire  [obj_fmt_pkg::byte_w-1:0]     cpu_dout,
    output logic [obj_fmt_pkg::byte_w-1:0]     obj_dout,
    input  wire  [obj_geom_pkg::x_w-1:0]       vpos,
    input  wire                                hbl,
    input  wire                                pxl_cen,
    output logic [obj_fmt_pkg::rom_aw-1:0]     rom_addr,
    input  wire  [obj_fmt_pkg::rom_dw-1:0]     rom_data,
    input  wire                                rom_ok,
    output logic [obj_fmt_pkg::pxl_w-1:0]      obj_pxl
);
    import obj_geom_pkg::*;
    import obj_fmt_pkg::*;

    logic [table_aw-1:0] scan_addr;
    logic                line_start, draw_start, draw_done;
    logic [row_w-1:0]    obj_row;
    logic [byte_w-1:0]   obj_code, obj_bank, obj_attr;
    logic [x_w-1:0]      obj_x;
    logic                buf_we;
    logic [x_w-1:0]      buf_x;
    logic [pxl_w-1:0]    buf_data;

    obj_table_ram u_table (
        .clk       (clk),
        .cpu_addr  (cpu_addr),
        .obj_cs    (obj_cs),
        .cpu_wrn   (cpu_wrn),
        .cpu_dout  (cpu_dout),
        .scan_addr (scan_addr),
        .obj_dout  (obj_dout)
    );

    obj_scan_fsm u_scan (
        .clk        (clk),
        .rst        (rst),
        .line_start (line_start),
        .vpos       (vpos),
        .obj_dout   (obj_dout),
        .draw_done  (draw_done),
        .obj_cs     (obj_cs),
        .scan_addr  (scan_addr),
        .draw_start (draw_start),
        .obj_row    (obj_row),
        .obj_code   (obj_code),
        .obj_bank   (obj_bank),
        .obj_x      (obj_x),
        .obj_attr   (obj_attr)
    );

    obj_draw u_draw (
        .clk        (clk),
        .rst        (rst),
        .draw_start (draw_start),
        .obj_row    (obj_row),
        .obj_code   (obj_code),
        .obj_bank   (obj_bank),
        .obj_x      (obj_x),
        .obj_attr   (obj_attr),
        .rom_data   (rom_data),
        .rom_ok     (rom_ok),
        .rom_addr   (rom_addr),
        .draw_done  (draw_done),
        .buf_we     (buf_we),
        .buf_x      (buf_x),
        .buf_data   (buf_data)
    );

    obj_line_buf u_line_buf (
        .clk        (clk),
        .rst        (rst),
        .hbl        (hbl),
        .pxl_cen    (pxl_cen),
        .buf_we     (buf_we),
        .buf_x      (buf_x),
        .buf_data   (buf_data),
        .line_start (line_start),
        .obj_pxl    (obj_pxl)
    );

endmodule

`default_nettype wire

// File: src/obj_line_buf.sv
`timescale 1ns/1ps
`default_nettype none

module obj_line_buf (
    input  wire                             clk,
    input  wire                             rst,
    input  wire                             hbl,
    input  wire                             pxl_cen,
    input  wire                             buf_we,
    input  wire  [obj_geom_pkg::x_w-1:0]    buf_x,
    input  wire  [obj_fmt_pkg::pxl_w-1:0]   buf_data,
    output logic                            line_start,
    output logic [obj_fmt_pkg::pxl_w-1:0]   obj_pxl
);
    import obj_geom_pkg::*;
    import obj_fmt_pkg::*;

    logic [pxl_w-1:0] mem [0:1][0:line_w-1];
    logic             hbl_l;
    logic             sel;     // bank on display
    logic             cen_d;
    logic [x_w-1:0]   rd_x, clr_x;
    logic [pxl_w-1:0] rd_q;

    assign line_start = hbl_l & ~hbl;

    // power-up contents, later kept clean by clear-after-read
    initial begin
        for (int b = 0; b < 2; b++) begin
            for (int i = 0; i < line_w; i++) begin
                mem[b][i] = '0;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hbl_l   <= 1'b0;
            sel     <= 1'b0;
            cen_d   <= 1'b0;
            rd_x    <= '0;
            obj_pxl <= '0;
        end else begin
            hbl_l <= hbl;
            cen_d <= pxl_cen;
            if (line_start) begin
                sel  <= ~sel;
                rd_x <= '0;
            end else if (pxl_cen) begin
                rd_x <= rd_x + 1'b1;
            end
            if (cen_d)
                obj_pxl <= rd_q;
        end
    end

    always @(posedge clk) begin
        if (pxl_cen) begin
            rd_q  <= mem[sel][rd_x];
            clr_x <= rd_x;
        end
        if (cen_d)
            mem[sel][clr_x] <= '0;  // wipe what was just shown
        if (buf_we)
            mem[~sel][buf_x] <= buf_data;
    end

endmodule

`default_nettype wire

// File: src/obj_pxl_count.sv
`timescale 1ns/1ps
`default_nettype none

module obj_pxl_count (
    input  wire                               clk,
    input  wire                               rst,
    input  wire                               start,
    input  wire  [obj_geom_pkg::x_w-1:0]      x0,
    input  wire                               step,
    output logic [obj_geom_pkg::pxl_iw-1:0]   pxl_idx,
    output logic [obj_geom_pkg::x_w-1:0]      pxl_x,
    output logic                              last
);
    import obj_geom_pkg::*;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pxl_idx <= '0;
            pxl_x   <= '0;
        end else if (start) begin
            pxl_idx <= '0;
            pxl_x   <= x0;
        end else if (step) begin
            pxl_idx <= pxl_idx + 1'b1;
            pxl_x   <= pxl_x + 1'b1;   // wraps at the line end
        end
    end

    assign last = pxl_idx == pxl_iw'(obj_w - 1);

endmodule

`default_nettype wire

// File: src/obj_scan_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module obj_scan_fsm (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                line_start,
    input  wire  [obj_geom_pkg::x_w-1:0]       vpos,
    input  wire  [obj_fmt_pkg::byte_w-1:0]     obj_dout,
    input  wire                                draw_done,
    input  wire                                obj_cs,
    output logic [obj_geom_pkg::table_aw-1:0]  scan_addr,
    output logic                               draw_start,
    output logic [obj_geom_pkg::row_w-1:0]     obj_row,
    output logic [obj_fmt_pkg::byte_w-1:0]     obj_code,
    output logic [obj_fmt_pkg::byte_w-1:0]     obj_bank,
    output logic [obj_geom_pkg::x_w-1:0]       obj_x,
    output logic [obj_fmt_pkg::byte_w-1:0]     obj_attr
);
    import obj_geom_pkg::*;
    import obj_fmt_pkg::*;

    // state: 0 idle, 1 read y, 2 read attr and test, 3 read bank,
    // 4 read code, 5 read x, 6 wait for draw
    logic [2:0]                      state;
    logic                            phase;     // second clock of a two-clock read
    logic [table_aw-1:0]             scan_base;
    logic [table_aw-1:0]             next_base;
    logic [$clog2(max_per_line)-1:0] draw_cnt;
    logic [2:0]                      offset;
    logic [byte_w-1:0]               obj_y;
    logic [x_w-1:0]                  row_full;
    logic                            visible;
    logic                            last_obj;

    assign row_full  = vpos - obj_y;  // wraps mod 256
    assign visible   = (row_full < obj_h) && obj_dout[attr_en];
    assign next_base = scan_base + table_aw'(obj_bytes);
    assign last_obj  = scan_base == table_aw'((obj_count - 1) * obj_bytes);

    always_comb begin
        case (state)
            3'd2:    offset = 3'(off_attr);
            3'd3:    offset = 3'(off_bank);
            3'd4:    offset = 3'(off_code);
            3'd5:    offset = 3'(off_x);
            default: offset = 3'(off_y);
        endcase
    end

    assign scan_addr = scan_base + table_aw'(offset);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= 3'd0;
            phase      <= 1'b0;
            scan_base  <= '0;
            draw_cnt   <= '0;
            draw_start <= 1'b0;
        end else begin
            draw_start <= 1'b0;
            // cpu access freezes the walk, draw wait keeps running
            if (!obj_cs || state == 3'd6) begin
                case (state)
                    3'd0: if (line_start) begin
                        state     <= 3'd1;
                        phase     <= 1'b0;
                        scan_base <= '0;
                        draw_cnt  <= '0;
                    end
                    3'd1: begin
                        phase <= ~phase;
                        if (phase)
                            state <= 3'd2;
                    end
                    3'd2: begin
                        phase <= ~phase;
                        if (phase) begin
                            if (visible) begin
                                state <= 3'd3;
                            end else if (last_obj) begin
                                state <= 3'd0;
                            end else begin
                                scan_base <= next_base; // skip to next entry
                                state     <= 3'd1;
                            end
                        end
                    end
                    3'd3: state <= 3'd4;
                    3'd4: state <= 3'd5;
                    3'd5: begin
                        phase <= ~phase;
                        if (phase) begin
                            draw_start <= 1'b1; // x lands on this edge
                            state      <= 3'd6;
                        end
                    end
                    3'd6: if (draw_done) begin
                        draw_cnt <= draw_cnt + 1'b1;
                        if (last_obj || draw_cnt == max_per_line - 1) begin
                            state <= 3'd0;
                        end else begin
                            scan_base <= next_base;
                            state     <= 3'd1;
                        end
                    end
                    default: state <= 3'd0;
                endcase
            end
        end
    end

    // table bytes arrive one clock after their address
    always_ff @(posedge clk) begin
        if (!obj_cs) begin
            case (state)
                3'd1: if (phase) obj_y <= obj_dout;
                3'd2: if (phase) begin
                    obj_attr <= obj_dout;
                    obj_row  <= row_full[row_w-1:0];
                end
                3'd4: obj_bank <= obj_dout;
                3'd5: begin
                    if (phase)
                        obj_x <= obj_dout;
                    else
                        obj_code <= obj_dout;
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/obj_table_ram.sv
`timescale 1ns/1ps
`default_nettype none

module obj_table_ram (
    input  wire                                clk,
    input  wire  [obj_geom_pkg::table_aw-1:0]  cpu_addr,
    input  wire                                obj_cs,
    input  wire                                cpu_wrn,
    input  wire  [obj_fmt_pkg::byte_w-1:0]     cpu_dout,
    input  wire  [obj_geom_pkg::table_aw-1:0]  scan_addr,
    output logic [obj_fmt_pkg::byte_w-1:0]     obj_dout
);
    import obj_geom_pkg::*;
    import obj_fmt_pkg::*;

    logic [byte_w-1:0]   mem [0:table_size-1];
    logic [table_aw-1:0] rd_addr;
    logic                we;

    assign we      = obj_cs & ~cpu_wrn;
    assign rd_addr = obj_cs ? cpu_addr : scan_addr; // cpu has priority

    // power-up contents
    initial begin
        for (int i = 0; i < table_size; i++) begin
            mem[i] = '0;
        end
    end

    always @(posedge clk) begin
        if (we)
            mem[cpu_addr] <= cpu_dout;
        obj_dout <= mem[rd_addr]; // read-before-write
    end

endmodule

`default_nettype wire

// File: tb/obj_rom_model.sv
`timescale 1ns/1ps
`default_nettype none

module obj_rom_model (
    input  wire                              clk,
    input  wire                              gaps,      // allow rom_ok drop-outs
    input  wire  [obj_fmt_pkg::rom_aw-1:0]   rom_addr,
    output logic [obj_fmt_pkg::rom_dw-1:0]   rom_data,
    output logic                             rom_ok
);
    import obj_fmt_pkg::*;

    logic [rom_dw-1:0] words [0:(1 << rom_aw)-1];
    logic              ok_next;
    integer            seed;

    initial begin
        seed     = 51845;
        rom_data = '0;
        rom_ok   = 1'b0;
        for (int a = 0; a < (1 << rom_aw); a++) begin
            words[a] = 16'(a * 40503) ^ 16'(a >> 2); // every address bit counts
        end
    end

    // outputs change on the falling edge like every other dut input
    always @(negedge clk) begin
        ok_next  = gaps ? (($random(seed) & 3) != 0) : 1'b1;
        rom_ok   <= ok_next;
        rom_data <= ok_next ? words[rom_addr] : ~words[rom_addr]; // junk while not ready
    end

endmodule

`default_nettype wire

// File: tb/tb_obj_layer.sv
`timescale 1ns/1ps
`default_nettype none

module tb_obj_layer;
    import obj_geom_pkg::*;
    import obj_fmt_pkg::*;

    localparam int hbl_cycles  = 200;
    localparam int line_cycles = 2 + line_w * 4 + hbl_cycles;
    // eleven video lines plus cpu table traffic
    localparam int timeout_cycles = 12 * line_cycles + 4000;

    logic                clk = 1'b0;
    logic                rst;
    logic [table_aw-1:0] cpu_addr;
    logic                obj_cs;
    logic                cpu_wrn;
    logic [byte_w-1:0]   cpu_dout;
    logic [byte_w-1:0]   obj_dout;
    logic [x_w-1:0]      vpos;
    logic [x_w-1:0]      cur_x;     // x of the last pixel strobe
    logic                hbl;
    logic                pxl_cen;
    logic                gaps;
    logic [rom_aw-1:0]   rom_addr;
    logic [rom_dw-1:0]   rom_data;
    logic                rom_ok;
    logic [pxl_w-1:0]    obj_pxl;
    logic [pxl_w-1:0]    exp_pxl;
    logic [byte_w-1:0]   exp_dout;
    logic                cen_d1, cen_d2, rd_d1;
    logic [byte_w-1:0]   table_copy [0:table_size-1];
    logic [pxl_w-1:0]    shown [0:line_w-1];     // line on display now
    logic [pxl_w-1:0]    pending [0:line_w-1];   // line being drawn now
    int                  cycles = 0;
    integer              seed;

    always #2 clk = ~clk;

    obj_layer u_obj_layer (
        .clk      (clk),
        .rst      (rst),
        .cpu_addr (cpu_addr),
        .obj_cs   (obj_cs),
        .cpu_wrn  (cpu_wrn),
        .cpu_dout (cpu_dout),
        .obj_dout (obj_dout),
        .vpos     (vpos),
        .hbl      (hbl),
        .pxl_cen  (pxl_cen),
        .rom_addr (rom_addr),
        .rom_data (rom_data),
        .rom_ok   (rom_ok),
        .obj_pxl  (obj_pxl)
    );

    obj_rom_model u_rom (
        .clk      (clk),
        .gaps     (gaps),
        .rom_addr (rom_addr),
        .rom_data (rom_data),
        .rom_ok   (rom_ok)
    );

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1, "stopped at the first error");
    endtask

    // pixel shows 2 clocks after its strobe, cpu byte 1 clock after the address
    assign exp_pxl = shown[cur_x];

    always @(posedge clk) begin
        cen_d1   <= pxl_cen;
        cen_d2   <= cen_d1;
        rd_d1    <= obj_cs & cpu_wrn;
        exp_dout <= table_copy[cpu_addr];
        cycles   <= cycles + 1;
        if (cycles == timeout_cycles)
            report_fail("timeout: the video sequence did not finish in time");
    end

    pixel_check: assert property (@(posedge clk) disable iff (rst)
        cen_d2 |-> obj_pxl == exp_pxl)
        else report_fail($sformatf("[FAIL] time %0t obj_pxl x=%0d expected %02h actual %02h",
            $time, $sampled(cur_x), $sampled(exp_pxl), $sampled(obj_pxl)));

    readback_check: assert property (@(posedge clk) disable iff (rst)
        rd_d1 |-> obj_dout == exp_dout)
        else report_fail($sformatf("[FAIL] time %0t obj_dout addr=%0d expected %02h actual %02h",
            $time, $sampled(cpu_addr), $sampled(exp_dout), $sampled(obj_dout)));

    task automatic cpu_write(input int addr, input logic [byte_w-1:0] data);
        @(negedge clk);
        obj_cs           = 1'b1;
        cpu_wrn          = 1'b0;
        cpu_addr         = table_aw'(addr);
        cpu_dout         = data;
        table_copy[addr] = data;
        @(negedge clk);
        obj_cs  = 1'b0;
        cpu_wrn = 1'b1;
    endtask

    task automatic cpu_read(input int addr);
        @(negedge clk);
        obj_cs   = 1'b1;
        cpu_wrn  = 1'b1;
        cpu_addr = table_aw'(addr);
        @(negedge clk);
        obj_cs = 1'b0;     // address stays put for the check
    endtask

    task automatic write_obj(input int n, input logic [7:0] y, attr, bank, code, x);
        cpu_write(n * obj_bytes + off_y, y);
        cpu_write(n * obj_bytes + off_attr, attr);
        cpu_write(n * obj_bytes + off_bank, bank);
        cpu_write(n * obj_bytes + off_code, code);
        cpu_write(n * obj_bytes + off_x, x);
    endtask

    task automatic check_obj(input int n);
        for (int b = 0; b < obj_bytes; b++) begin
            cpu_read(n * obj_bytes + b);
        end
    endtask

    task automatic clear_objs(input int count);
        for (int n = 0; n < count; n++) begin
            write_obj(n, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00);
        end
    endtask

    // expected line for scan line v, later table entries paint over earlier ones
    task automatic render_line(input logic [7:0] v);
        int          drawn;
        int          base;
        int          s;
        int          w;
        int          k;
        logic [7:0]  y, attr, bank, code, x, row;
        logic [15:0] word;
        logic [3:0]  colour;
        for (int i = 0; i < line_w; i++) begin
            pending[i] = '0;
        end
        drawn = 0;
        for (int n = 0; n < obj_count; n++) begin
            base = n * obj_bytes;
            y    = table_copy[base + off_y];
            attr = table_copy[base + off_attr];
            bank = table_copy[base + off_bank];
            code = table_copy[base + off_code];
            x    = table_copy[base + off_x];
            row  = v - y;
            if (row < obj_h && attr[attr_en] && drawn < max_per_line) begin
                drawn++;
                if (attr[attr_vflip])
                    row = 8'd15 - row;
                for (int p = 0; p < obj_w; p++) begin
                    s      = attr[attr_hflip] ? 15 - p : p;
                    w      = s / 4;
                    k      = s % 4;
                    word   = u_rom.words[{bank[3:0], code, row[3:0], w[1:0]}];
                    colour = {word[k+12], word[k+8], word[k+4], word[k]};
                    if (colour != 4'd0)
                        pending[8'(x + p)] = {bank[7:4], colour};
                end
            end
        end
    endtask

    // one video line, what the scan of the previous line drew is on display
    task automatic run_line(input logic [7:0] v);
        @(negedge clk);
        vpos = v;
        hbl  = 1'b0;
        for (int i = 0; i < line_w; i++) begin
            shown[i] = pending[i];
        end
        render_line(v);
        @(negedge clk);    // bank swap happens here
        for (int x = 0; x < line_w; x++) begin
            @(negedge clk);
            pxl_cen = 1'b1;
            cur_x   = 8'(x);
            @(negedge clk);
            pxl_cen = 1'b0;
            repeat (2) @(negedge clk);
        end
        hbl = 1'b1;
        repeat (hbl_cycles) @(negedge clk);
    endtask

    initial begin
        rst      = 1'b1;
        cpu_addr = '0;
        obj_cs   = 1'b0;
        cpu_wrn  = 1'b1;
        cpu_dout = '0;
        vpos     = '0;
        hbl      = 1'b1;
        pxl_cen  = 1'b0;
        cur_x    = '0;
        gaps     = 1'b1;
        seed     = 51845;
        for (int i = 0; i < table_size; i++) begin
            table_copy[i] = '0;
        end
        for (int i = 0; i < line_w; i++) begin
            shown[i]   = '0;
            pending[i] = '0;
        end
        repeat (10) @(negedge clk);
        rst = 1'b0;

        // whole table through the cpu port
        for (int a = 0; a < table_size; a++) begin
            cpu_write(a, 8'($random(seed)));
        end
        for (int a = 0; a < table_size; a++) begin
            cpu_read(a);
        end
        for (int a = 0; a < table_size; a++) begin
            cpu_write(a, 8'h00);
        end

        // plain object, disabled, out of band, overlap
        write_obj(0, 8'd20, 8'h80, 8'h35, 8'h12, 8'd40);
        write_obj(1, 8'd20, 8'h00, 8'h47, 8'h21, 8'd100);
        write_obj(2, 8'd100, 8'h80, 8'h52, 8'h33, 8'd130);
        write_obj(3, 8'd18, 8'h80, 8'h6a, 8'h44, 8'd48);
        for (int n = 0; n < 4; n++) begin
            check_obj(n);
        end
        run_line(8'd25);
        run_line(8'd26);

        // hflip, vflip, both, x wrap
        clear_objs(4);
        write_obj(0, 8'd32, 8'h88, 8'h71, 8'h05, 8'd10);
        write_obj(1, 8'd35, 8'h84, 8'h83, 8'h06, 8'd60);
        write_obj(2, 8'd30, 8'h8c, 8'h9c, 8'h07, 8'd110);
        write_obj(3, 8'd40, 8'h80, 8'ha2, 8'h08, 8'd250);
        run_line(8'd40);
        run_line(8'd41);

        // 34 objects in one band, the last two must not show
        gaps = 1'b0;   // 32 draws only just fit in one line at full rom speed
        clear_objs(4);
        for (int i = 0; i < max_per_line + 2; i++) begin
            write_obj(i, 8'd60, 8'h80 | 8'((i % 4) << 2), 8'(i * 29 + 1),
                      8'(i * 3 + 7), 8'(i * 7));
        end
        run_line(8'd65);
        run_line(8'd66);

        // rom stalls and a different object set on every line
        gaps = 1'b1;
        clear_objs(max_per_line + 2);
        write_obj(0, 8'd120, 8'h80, 8'hc1, 8'h50, 8'd20);
        write_obj(1, 8'd137, 8'h88, 8'hd2, 8'h51, 8'd24);
        write_obj(2, 8'd134, 8'h84, 8'he3, 8'h52, 8'd200);
        write_obj(3, 8'd130, 8'h00, 8'hf4, 8'h53, 8'd90);
        for (int v = 134; v <= 138; v++) begin
            run_line(8'(v));
        end

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire
